//--- design/corr_pkg.sv
/*
 * Shared definitions of the photon-counting cross-correlator.
 * APB register word addresses, APB transfer phases and the
 * derived counts that size the baseline and lag arrays.
 */

package corr_pkg;

	// ****************************************
	// Register map
	// ****************************************

	typedef enum logic [7:0] {
		CTRL     = 8'h00, // Bit0 enable, bit1 clear.
		MASK     = 8'h04, // Input enable bits.
		STATUS   = 8'h08, // Bit0 any-overflow.
		SAMPLES  = 8'h0C, // Ticks counted while enabled.
		CNT_BASE = 8'h40  // Start of the counter window.
	} reg_addr_e;

	// ****************************************
	// APB transfer phases
	// ****************************************

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} apb_state_e;

	// Number of input pairs a<b.
	function automatic int num_baselines(input int n);
		return n * (n - 1) / 2;
	endfunction

	// Lags from -(l-1) to +(l-1).
	function automatic int num_lags(input int l);
		return 2 * l - 1;
	endfunction

	// Ones counters first, then every baseline with all of its lags.
	function automatic int num_counters(input int n, input int l);
		return n + num_baselines(n) * num_lags(l);
	endfunction

endpackage

//--- design/sample_strobe.sv
/*
 * Sample strobe generator.
 * Brings the external sample clock into the pllclk domain and
 * turns each of its rising edges into a single-cycle tick.
 */

`timescale 1ns/1ps

module sample_strobe (
	input  logic pllclk,
	input  logic reset,
	input  logic smpclk,
	output logic tick
);

	logic smp_meta;
	logic smp_sync;
	logic smp_prev;

	// Two flops against metastability, then the edge register.
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			smp_meta <= 1'b0;
			smp_sync <= 1'b0;
			smp_prev <= 1'b0;
			tick     <= 1'b0;
		end else begin
			smp_meta <= smpclk;
			smp_sync <= smp_meta;
			smp_prev <= smp_sync;
			tick     <= smp_sync & ~smp_prev; // High for one cycle per rising edge.
		end
	end

endmodule

//--- design/input_channel.sv
/*
 * One input line of the correlator.
 * Synchronizer, the tap register that feeds the baselines and
 * the saturating count of ones.
 */

`timescale 1ns/1ps

module input_channel #(
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16
) (
	input  logic                  pllclk,
	input  logic                  reset,
	input  logic                  tick,
	input  logic                  enable,
	input  logic                  clear,
	input  logic                  mask_bit,
	input  logic                  sample,
	output logic [LAG_CROSS-1:0]  taps,
	output logic [RESOLUTION-1:0] count,
	output logic                  overflow
);

	logic sample_meta;
	logic sample_sync;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			sample_meta <= 1'b0;
			sample_sync <= 1'b0;
		end else begin
			sample_meta <= sample;
			sample_sync <= sample_meta;
		end
	end

	// Tap 0 holds the newest sample, older ones move up on every tick.
	always_ff @(posedge pllclk) begin
		if (!reset || clear) begin
			taps <= '0;
		end else if (tick) begin
			for (int i = LAG_CROSS - 1; i > 0; i--) begin
				taps[i] <= taps[i-1];
			end
			taps[0] <= sample_sync;
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset || clear) begin
			count    <= '0;
			overflow <= 1'b0;
		end else if (tick && enable && mask_bit && sample_sync) begin
			if (&count)
				overflow <= 1'b1; // Full scale, the count holds.
			else
				count <= count + 1'b1;
		end
	end

endmodule

//--- design/baseline_correlator.sv
/*
 * Coincidence counters of one baseline.
 * One saturating counter per relative lag between the tap
 * registers of inputs a and b.
 */

`timescale 1ns/1ps

module baseline_correlator #(
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16
) (
	input  logic                                                   pllclk,
	input  logic                                                   reset,
	input  logic                                                   tick,
	input  logic                                                   enable,
	input  logic                                                   clear,
	input  logic                                                   pair_enable,
	input  logic [LAG_CROSS-1:0]                                   taps_a,
	input  logic [LAG_CROSS-1:0]                                   taps_b,
	output logic [corr_pkg::num_lags(LAG_CROSS)*RESOLUTION-1:0]    counts,
	output logic [corr_pkg::num_lags(LAG_CROSS)-1:0]               overflow
);

	localparam int NUM_LAGS = corr_pkg::num_lags(LAG_CROSS);

	logic                tick_q;
	logic [NUM_LAGS-1:0] hit;

	// The channel taps shift on the tick, so the counters act one
	// cycle later on the updated tap registers.
	always_ff @(posedge pllclk) begin
		if (!reset)
			tick_q <= 1'b0;
		else
			tick_q <= tick;
	end

	// ****************************************
	// Lag counters
	// ****************************************

	genvar j;
	generate
		for (j = 0; j < NUM_LAGS; j++) begin : g_lag
			// Negative lag delays input a, positive lag delays input b.
			localparam int LAG = j - (LAG_CROSS - 1);
			localparam int IDX_A = (LAG < 0) ? -LAG : 0;
			localparam int IDX_B = (LAG > 0) ? LAG : 0;

			logic [RESOLUTION-1:0] cnt_q;
			logic                  ovf_q;

			assign hit[j] = taps_a[IDX_A] & taps_b[IDX_B];

			always_ff @(posedge pllclk) begin
				if (!reset || clear) begin
					cnt_q <= '0;
					ovf_q <= 1'b0;
				end else if (tick_q && enable && pair_enable && hit[j]) begin
					if (&cnt_q)
						ovf_q <= 1'b1;
					else
						cnt_q <= cnt_q + 1'b1;
				end
			end

			assign counts[j*RESOLUTION +: RESOLUTION] = cnt_q;
			assign overflow[j] = ovf_q;
		end
	endgenerate

endmodule

//--- design/correlator_regs.sv
/*
 * APB register slave of the correlator.
 * Control and mask registers, overflow status, the sample
 * counter and the readout window over all counters.
 */

`timescale 1ns/1ps

module correlator_regs #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16,
	parameter int NUM_COUNTERS = corr_pkg::num_counters(NUM_INPUTS, LAG_CROSS)
) (
	input  logic                               pllclk,
	input  logic                               reset,
	input  logic                               tick,
	input  logic [7:0]                         paddr,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [31:0]                        pwdata,
	output logic [31:0]                        prdata,
	output logic                               pready,
	output logic                               pslverr,
	output logic                               enable,
	output logic                               clear,
	output logic [NUM_INPUTS-1:0]              mask,
	input  logic [NUM_COUNTERS*RESOLUTION-1:0] counts,
	input  logic [NUM_COUNTERS-1:0]            overflow
);

	corr_pkg::apb_state_e state;

	logic [RESOLUTION-1:0] samples_q;
	logic [5:0]            win_idx;
	logic                  in_window;
	logic                  addr_ok;
	logic                  read_only;
	logic                  err;
	logic [31:0]           rd_data;

	assign pready = 1'b1; // No wait states.

	always_comb begin
		if (!psel)
			state = corr_pkg::IDLE;
		else if (!penable)
			state = corr_pkg::SETUP;
		else
			state = corr_pkg::ACCESS;
	end

	// ****************************************
	// Address decode and read data
	// ****************************************

	assign win_idx   = paddr[7:2] - 6'(corr_pkg::CNT_BASE >> 2);
	assign in_window = (paddr >= corr_pkg::CNT_BASE) && (paddr[1:0] == 2'b00) &&
		(int'(win_idx) < NUM_COUNTERS);

	always_comb begin
		rd_data   = '0;
		addr_ok   = 1'b1;
		read_only = 1'b0;
		case (paddr)
			corr_pkg::CTRL:    rd_data[0] = enable; // Clear always reads 0.
			corr_pkg::MASK:    rd_data[NUM_INPUTS-1:0] = mask;
			corr_pkg::STATUS: begin
				rd_data[0] = |overflow;
				read_only  = 1'b1;
			end
			corr_pkg::SAMPLES: begin
				rd_data[RESOLUTION-1:0] = samples_q;
				read_only = 1'b1;
			end
			default: begin
				read_only = 1'b1;
				if (in_window)
					rd_data[RESOLUTION-1:0] = counts[win_idx*RESOLUTION +: RESOLUTION];
				else
					addr_ok = 1'b0;
			end
		endcase
	end

	assign err = !addr_ok || (pwrite && read_only);

	// Response is prepared in SETUP and presented during ACCESS.
	always_ff @(posedge pllclk) begin
		if (!reset)
			pslverr <= 1'b0;
		else
			pslverr <= (state == corr_pkg::SETUP) && err;
	end

	always_ff @(posedge pllclk) begin
		if (state == corr_pkg::SETUP && !pwrite)
			prdata <= rd_data;
	end

	// ****************************************
	// Control registers
	// ****************************************

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			enable <= 1'b0;
			clear  <= 1'b0;
			mask   <= '0;
		end else begin
			clear <= 1'b0;
			if (state == corr_pkg::ACCESS && pwrite && !err) begin
				if (paddr == corr_pkg::CTRL) begin
					enable <= pwdata[0];
					clear  <= pwdata[1]; // One-cycle pulse.
				end
				if (paddr == corr_pkg::MASK)
					mask <= pwdata[NUM_INPUTS-1:0];
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset || clear)
			samples_q <= '0;
		else if (tick && enable && !(&samples_q))
			samples_q <= samples_q + 1'b1;
	end

endmodule

//--- design/correlator_top.sv
/*
 * Top level of the cross-correlator.
 * Sample strobe, one channel per input, one correlator per
 * baseline and the APB register slave.
 */

`timescale 1ns/1ps

module correlator_top #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16
) (
	input  logic                  pllclk,
	input  logic                  reset,
	input  logic                  smpclk,
	input  logic [NUM_INPUTS-1:0] samples,
	input  logic [7:0]            paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr
);

	localparam int NUM_LAGS     = corr_pkg::num_lags(LAG_CROSS);
	localparam int NUM_COUNTERS = corr_pkg::num_counters(NUM_INPUTS, LAG_CROSS);

	logic                               tick;
	logic                               enable;
	logic                               clear;
	logic [NUM_INPUTS-1:0]              mask;
	logic [LAG_CROSS-1:0]               taps [NUM_INPUTS];
	logic [NUM_COUNTERS*RESOLUTION-1:0] counts;
	logic [NUM_COUNTERS-1:0]            overflow;

	sample_strobe strobe0 (
		.pllclk (pllclk),
		.reset  (reset),
		.smpclk (smpclk),
		.tick   (tick)
	);

	genvar a, b;
	generate
		for (a = 0; a < NUM_INPUTS; a++) begin : g_chan
			input_channel #(.LAG_CROSS(LAG_CROSS), .RESOLUTION(RESOLUTION)) chan (
				.pllclk   (pllclk),
				.reset    (reset),
				.tick     (tick),
				.enable   (enable),
				.clear    (clear),
				.mask_bit (mask[a]),
				.sample   (samples[a]),
				.taps     (taps[a]),
				.count    (counts[a*RESOLUTION +: RESOLUTION]),
				.overflow (overflow[a])
			);
		end

		// Baselines in the order (0,1),(0,2)...(n-2,n-1), after the ones counters.
		for (a = 0; a < NUM_INPUTS - 1; a++) begin : g_row
			for (b = a + 1; b < NUM_INPUTS; b++) begin : g_col
				localparam int BL   = a * NUM_INPUTS - a * (a + 1) / 2 + (b - a - 1);
				localparam int SLOT = NUM_INPUTS + BL * NUM_LAGS;

				baseline_correlator #(.LAG_CROSS(LAG_CROSS), .RESOLUTION(RESOLUTION)) corr (
					.pllclk      (pllclk),
					.reset       (reset),
					.tick        (tick),
					.enable      (enable),
					.clear       (clear),
					.pair_enable (mask[a] & mask[b]),
					.taps_a      (taps[a]),
					.taps_b      (taps[b]),
					.counts      (counts[SLOT*RESOLUTION +: NUM_LAGS*RESOLUTION]),
					.overflow    (overflow[SLOT +: NUM_LAGS])
				);
			end
		end
	endgenerate

	correlator_regs #(
		.NUM_INPUTS   (NUM_INPUTS),
		.LAG_CROSS    (LAG_CROSS),
		.RESOLUTION   (RESOLUTION),
		.NUM_COUNTERS (NUM_COUNTERS)
	) regs0 (
		.pllclk   (pllclk),
		.reset    (reset),
		.tick     (tick),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.enable   (enable),
		.clear    (clear),
		.mask     (mask),
		.counts   (counts),
		.overflow (overflow)
	);

endmodule

//--- sim/clock_gen.sv
/*
 * Testbench clock and reset source.
 * 8 ns pllclk and an active-low reset held for 4 cycles.
 */

`timescale 1ns/1ps

module clock_gen (
	output logic pllclk,
	output logic reset
);

	initial begin
		pllclk = 1'b0;
		forever #4 pllclk = ~pllclk;
	end

	initial begin
		reset = 1'b0;
		repeat (4) @(posedge pllclk);
		reset <= 1'b1; // Released on a clock edge, like any other input.
	end

endmodule

//--- sim/correlator_checker.sv
/*
 * Concurrent assertions on the correlator top level.
 * APB response rules, tick width and counter monotonicity,
 * bound into every correlator_top instance.
 */

`timescale 1ns/1ps

module correlator_checker #(
	parameter int NUM_COUNTERS = 22,
	parameter int RESOLUTION   = 16
) (
	input logic                               pllclk,
	input logic                               reset,
	input logic                               psel,
	input logic                               penable,
	input logic                               pready,
	input logic                               pslverr,
	input logic                               tick,
	input logic                               clear,
	input logic [NUM_COUNTERS*RESOLUTION-1:0] counts
);

	int violations = 0; // Number of failed assertions so far.

	pready_high: assert property (@(posedge pllclk) disable iff (!reset) pready)
		else begin
			$error("pready went low");
			violations++;
		end

	err_in_access: assert property (@(posedge pllclk) disable iff (!reset)
		pslverr |-> (psel && penable))
		else begin
			$error("pslverr raised outside the ACCESS phase");
			violations++;
		end

	tick_single: assert property (@(posedge pllclk) disable iff (!reset) tick |=> !tick)
		else begin
			$error("tick stayed high for two cycles");
			violations++;
		end

	// A counter only moves up or holds unless clear was pulsed.
	genvar i;
	generate
		for (i = 0; i < NUM_COUNTERS; i++) begin : g_cnt
			cnt_no_decrease: assert property (@(posedge pllclk) disable iff (!reset)
				!clear |=> (counts[i*RESOLUTION +: RESOLUTION] >=
					$past(counts[i*RESOLUTION +: RESOLUTION])))
				else begin
					$error("counter %0d decreased without clear", i);
					violations++;
				end
		end
	endgenerate

endmodule

bind correlator_top correlator_checker #(
	.NUM_COUNTERS (NUM_COUNTERS),
	.RESOLUTION   (RESOLUTION)
) chk0 (
	.pllclk  (pllclk),
	.reset   (reset),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.pslverr (pslverr),
	.tick    (tick),
	.clear   (clear),
	.counts  (counts)
);

//--- sim/correlator_tb.sv
/*
 * Testbench of the cross-correlator.
 * Random sample stimulus, APB access tasks, a reference model of
 * the ones and lag coincidence counters, six tests and the report.
 */

`timescale 1ns/1ps

module correlator_tb;

	localparam int NUM_INPUTS    = 4;
	localparam int LAG_CROSS     = 2;
	localparam int RESOLUTION    = 8;
	localparam int NUM_LAGS      = 2 * LAG_CROSS - 1;
	localparam int NUM_COUNTERS  = NUM_INPUTS + NUM_INPUTS * (NUM_INPUTS - 1) / 2 * NUM_LAGS;
	localparam int CNT_MAX       = (1 << RESOLUTION) - 1;
	localparam int SAMPLE_CYCLES = 24; // Length of one sample_step.
	localparam int TOTAL_SAMPLES = 440;
	localparam int TIMEOUT_NS    = TOTAL_SAMPLES * SAMPLE_CYCLES * 8 + 20000;

	localparam logic [7:0] ADDR_CTRL    = 8'h00;
	localparam logic [7:0] ADDR_MASK    = 8'h04;
	localparam logic [7:0] ADDR_STATUS  = 8'h08;
	localparam logic [7:0] ADDR_SAMPLES = 8'h0C;
	localparam logic [7:0] ADDR_WINDOW  = 8'h40;

	logic                  pllclk;
	logic                  reset;
	logic                  smpclk;
	logic [NUM_INPUTS-1:0] samples;
	logic [7:0]            paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	integer seed;
	integer rnd;
	int     test_errors;
	int     tests_passed;
	int     tests_failed;
	int     checker_seen;

	// Reference model state.
	int                   m_cnt [NUM_COUNTERS];
	logic [LAG_CROSS-1:0] m_taps [NUM_INPUTS];
	int                   m_samples;
	logic                 m_ovf;
	logic                 m_en;
	logic [NUM_INPUTS-1:0] m_mask;

	clock_gen clk0 (
		.pllclk (pllclk),
		.reset  (reset)
	);

	correlator_top #(
		.NUM_INPUTS (NUM_INPUTS),
		.LAG_CROSS  (LAG_CROSS),
		.RESOLUTION (RESOLUTION)
	) dut0 (
		.pllclk  (pllclk),
		.reset   (reset),
		.smpclk  (smpclk),
		.samples (samples),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	// ****************************************
	// Reference model
	// ****************************************

	task automatic model_clear();
		for (int i = 0; i < NUM_COUNTERS; i++)
			m_cnt[i] = 0;
		for (int i = 0; i < NUM_INPUTS; i++)
			m_taps[i] = '0;
		m_samples = 0;
		m_ovf     = 1'b0;
	endtask

	task automatic count_up(input int idx);
		if (m_cnt[idx] == CNT_MAX)
			m_ovf = 1'b1; // Saturated counter holds and flags.
		else
			m_cnt[idx]++;
	endtask

	task automatic model_tick(input logic [NUM_INPUTS-1:0] smp);
		int bl;
		int m;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int k = LAG_CROSS - 1; k > 0; k--)
				m_taps[i][k] = m_taps[i][k-1];
			m_taps[i][0] = smp[i];
		end
		if (!m_en)
			return;
		if (m_samples < CNT_MAX)
			m_samples++;
		for (int i = 0; i < NUM_INPUTS; i++)
			if (m_mask[i] && smp[i])
				count_up(i);
		bl = 0;
		for (int a = 0; a < NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				for (int j = 0; j < NUM_LAGS; j++) begin
					m = j - (LAG_CROSS - 1);
					if (m_mask[a] && m_mask[b] && m_taps[a][m < 0 ? -m : 0] &&
						m_taps[b][m > 0 ? m : 0])
						count_up(NUM_INPUTS + bl * NUM_LAGS + j);
				end
				bl++;
			end
		end
	endtask

	// ****************************************
	// Stimulus and APB tasks
	// ****************************************

	// One smpclk period. Samples settle while smpclk is low.
	task automatic sample_step(input logic [NUM_INPUTS-1:0] value);
		samples <= value;
		repeat (6) @(posedge pllclk);
		smpclk <= 1'b1;
		model_tick(value);
		repeat (12) @(posedge pllclk);
		smpclk <= 1'b0;
		repeat (6) @(posedge pllclk);
	endtask

	task automatic run_samples(input int count, input logic all_ones);
		repeat (count) begin
			rnd = $random(seed);
			sample_step(all_ones ? '1 : rnd[NUM_INPUTS-1:0]);
		end
		repeat (10) @(posedge pllclk); // Let the last tick reach the counters.
	endtask

	task automatic apb_xfer(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge pllclk);
		paddr   <= addr;
		pwrite  <= write;
		pwdata  <= wdata;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge pllclk);
		penable <= 1'b1;
		@(negedge pllclk);
		rdata = prdata;
		err   = pslverr;
		@(posedge pllclk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_xfer(addr, 1'b1, data, rd, err);
		assert (!err)
		else begin
			$display("ERROR at %0t ns: write to 0x%02h raised pslverr", $time, addr);
			test_errors++;
		end
		if (addr == ADDR_CTRL) begin
			m_en = data[0];
			if (data[1])
				model_clear();
		end else if (addr == ADDR_MASK) begin
			m_mask = data[NUM_INPUTS-1:0];
		end
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] data;
		logic        err;
		apb_xfer(addr, 1'b0, 32'h0, data, err);
		assert (!err && data == exp)
		else begin
			$display("ERROR at %0t ns: %s read 0x%08h (pslverr %0b), expected 0x%08h",
				$time, what, data, err, exp);
			test_errors++;
		end
	endtask

	task automatic check_slverr(input logic [7:0] addr, input logic write, input string what);
		logic [31:0] data;
		logic        err;
		apb_xfer(addr, write, 32'h0, data, err);
		assert (err)
		else begin
			$display("ERROR at %0t ns: %s gave no pslverr", $time, what);
			test_errors++;
		end
	endtask

	task automatic check_counters(input int first, input int last);
		for (int i = first; i <= last; i++)
			check_read(8'(ADDR_WINDOW + 4 * i), 32'(m_cnt[i]), $sformatf("counter %0d", i));
	endtask

	// Failures of the bound assertions count against the test that was running.
	task automatic finish_test(input string name);
		int fails;
		fails = test_errors + dut0.chk0.violations - checker_seen;
		checker_seen = dut0.chk0.violations;
		if (fails == 0) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, fails);
		end
		test_errors = 0;
	endtask

	// ****************************************
	// Tests
	// ****************************************

	initial begin
		seed    = 32'heb75_d361;
		smpclk  = 1'b0;
		samples = '0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		m_en    = 1'b0;
		m_mask  = '0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		checker_seen = 0;
		model_clear();
		wait (reset === 1'b1);
		repeat (2) @(posedge pllclk);

		check_read(ADDR_CTRL, 32'h0, "CTRL");
		check_read(ADDR_MASK, 32'h0, "MASK");
		check_read(ADDR_STATUS, 32'h0, "STATUS");
		check_read(ADDR_SAMPLES, 32'h0, "SAMPLES");
		check_counters(0, NUM_COUNTERS - 1);
		check_slverr(ADDR_STATUS, 1'b1, "write to STATUS");
		check_slverr(8'h10, 1'b0, "read of unmapped address 0x10");
		check_slverr(8'(ADDR_WINDOW + 4 * NUM_COUNTERS), 1'b0, "read past the last counter");
		finish_test("1 reset and register map");

		write_reg(ADDR_MASK, 32'hF);
		write_reg(ADDR_CTRL, 32'h1);
		run_samples(60, 1'b0);
		check_read(ADDR_SAMPLES, 32'(m_samples), "SAMPLES");
		check_counters(0, NUM_INPUTS - 1);
		finish_test("2 ones counts");

		check_counters(NUM_INPUTS, NUM_COUNTERS - 1);
		check_read(ADDR_STATUS, 32'(m_ovf), "STATUS");
		finish_test("3 lag coincidences");

		write_reg(ADDR_MASK, 32'hB); // Input 2 masked off.
		run_samples(20, 1'b0);
		check_counters(0, NUM_COUNTERS - 1);
		write_reg(ADDR_CTRL, 32'h0);
		run_samples(20, 1'b0);
		check_counters(0, NUM_COUNTERS - 1);
		check_read(ADDR_SAMPLES, 32'(m_samples), "SAMPLES while disabled");
		finish_test("4 mask and enable");

		write_reg(ADDR_CTRL, 32'h2);
		check_counters(0, NUM_COUNTERS - 1);
		check_read(ADDR_STATUS, 32'h0, "STATUS after clear");
		check_read(ADDR_SAMPLES, 32'h0, "SAMPLES after clear");
		write_reg(ADDR_MASK, 32'hF);
		write_reg(ADDR_CTRL, 32'h1);
		run_samples(40, 1'b0);
		check_counters(0, NUM_COUNTERS - 1);
		check_read(ADDR_SAMPLES, 32'(m_samples), "SAMPLES");
		finish_test("5 clear");

		run_samples(300, 1'b1);
		for (int i = 0; i < NUM_COUNTERS; i++)
			check_read(8'(ADDR_WINDOW + 4 * i), CNT_MAX, $sformatf("saturated counter %0d", i));
		check_read(ADDR_STATUS, 32'h1, "STATUS overflow");
		check_read(ADDR_SAMPLES, CNT_MAX, "saturated SAMPLES");
		finish_test("6 saturation");

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired: the tests did not finish in the expected time.");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
design/corr_pkg.sv
design/sample_strobe.sv
design/input_channel.sv
design/baseline_correlator.sv
design/correlator_regs.sv
design/correlator_top.sv
sim/clock_gen.sv
sim/correlator_checker.sv
sim/correlator_tb.sv
